// ==== tcp_rx_defs.svh ====
`ifndef TCP_RX_DEFS_SVH
`define TCP_RX_DEFS_SVH

// descriptor field widths
`define TCP_RX_FLOW_W 8
`define TCP_RX_SEQ_W 32
`define TCP_RX_LEN_W 16

// fifo address widths
`define TCP_RX_PD_FIFO_AW 4
`define TCP_RX_RSLT_FIFO_AW 4
`define TCP_RX_AFULL_MARGIN 2

// lookups allowed between request and write-back
`define TCP_RX_MAX_INFLIGHT 4
`define TCP_RX_HIST_DEPTH 4

`endif

// ==== tcp_rx_pkg.sv ====
package tcp_rx_pkg;
  `include "tcp_rx_defs.svh"

  typedef logic [`TCP_RX_FLOW_W-1:0] flow_idx_t;
  typedef logic [`TCP_RX_SEQ_W-1:0] seq_num_t;
  typedef logic [`TCP_RX_LEN_W-1:0] pay_len_t;
  typedef logic [7:0] tcp_flags_t;

  // flow | seq | len | flags, flow on top
  typedef logic [`TCP_RX_FLOW_W+`TCP_RX_SEQ_W+`TCP_RX_LEN_W+8-1:0] pkt_desc_t;

  typedef enum logic [1:0] {
    RX_ACCEPT   = 2'd0,
    RX_SYN_INIT = 2'd1,
    RX_DROP_OOO = 2'd2
  } rx_verdict_e;

  // verdict above the descriptor
  typedef logic [$bits(rx_verdict_e)+$bits(pkt_desc_t)-1:0] out_desc_t;

  localparam int SYN_BIT = 1;
  localparam int LEN_LSB = $bits(tcp_flags_t);
  localparam int SEQ_LSB = LEN_LSB + `TCP_RX_LEN_W;
  localparam int FLOW_LSB = SEQ_LSB + `TCP_RX_SEQ_W;

  function automatic flow_idx_t desc_flow(pkt_desc_t d);
    return d[FLOW_LSB +: `TCP_RX_FLOW_W];
  endfunction

  function automatic seq_num_t desc_seq(pkt_desc_t d);
    return d[SEQ_LSB +: `TCP_RX_SEQ_W];
  endfunction

  function automatic pay_len_t desc_len(pkt_desc_t d);
    return d[LEN_LSB +: `TCP_RX_LEN_W];
  endfunction

  function automatic tcp_flags_t desc_flags(pkt_desc_t d);
    return d[0 +: $bits(tcp_flags_t)];
  endfunction
endpackage

// ==== sync_fifo.sv ====
`timescale 1ns/10ps
`include "tcp_rx_defs.svh"

module sync_fifo #(
  parameter int DWID = 64,
  parameter int AWID = 4
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            wen,
  input  logic [DWID-1:0] wdata,
  output logic            nafull,
  input  logic            ren,
  output logic [DWID-1:0] rdata,
  output logic            nempty
);

  localparam int DEPTH = 1 << AWID;
  localparam int CNT_W = AWID + 1;

  logic [DWID-1:0]  mem [DEPTH];
  logic [AWID-1:0]  wptr;
  logic [AWID-1:0]  rptr;
  logic [CNT_W-1:0] cnt_used;
  logic             do_wr;
  logic             do_rd;

  // ignore writes when full and reads when empty
  assign do_wr = wen && (cnt_used != CNT_W'(DEPTH));
  assign do_rd = ren && (cnt_used != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wptr     <= '0;
      rptr     <= '0;
      cnt_used <= '0;
    end else begin
      if (do_wr) begin
        wptr <= wptr + AWID'(1);
      end
      if (do_rd) begin
        rptr <= rptr + AWID'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   cnt_used <= cnt_used + CNT_W'(1);
        2'b01:   cnt_used <= cnt_used - CNT_W'(1);
        default: cnt_used <= cnt_used;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wptr] <= wdata;
    end
  end

  // show-ahead head
  assign rdata  = mem[rptr];
  assign nempty = (cnt_used != '0);

  // high while more than the margin is free
  assign nafull = (cnt_used < CNT_W'(DEPTH - `TCP_RX_AFULL_MARGIN));

endmodule

// ==== tcp_rx_tab_req.sv ====
`timescale 1ns/10ps
`include "tcp_rx_defs.svh"

module tcp_rx_tab_req
  import tcp_rx_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,

  input  logic      in_pd_vld,
  output logic      in_pd_rdy,
  input  pkt_desc_t in_pd_dat,

  output logic      tab_rreq_wen,
  output flow_idx_t tab_rreq_addr,
  input  logic      tab_rreq_nafull,

  output logic      pd_fifo_wen,
  output pkt_desc_t pd_fifo_wdata,
  input  logic      pd_fifo_nafull,

  input  logic      retire
);

  localparam int MAX_INFL = `TCP_RX_MAX_INFLIGHT;
  localparam int CNT_W = $clog2(MAX_INFL + 1);

  logic [CNT_W-1:0] inflight_cnt;
  logic             infl_ok;
  logic             accept;

  assign infl_ok = (inflight_cnt < CNT_W'(MAX_INFL));

  // ready only toward a waiting descriptor
  assign accept    = in_pd_vld && tab_rreq_nafull && pd_fifo_nafull && infl_ok;
  assign in_pd_rdy = accept;

  // table read and descriptor push in the same cycle
  assign tab_rreq_wen  = accept;
  assign tab_rreq_addr = desc_flow(in_pd_dat);
  assign pd_fifo_wen   = accept;
  assign pd_fifo_wdata = in_pd_dat;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      inflight_cnt <= '0;
    end else begin
      case ({accept, retire})
        2'b10:   inflight_cnt <= inflight_cnt + CNT_W'(1);
        2'b01:   inflight_cnt <= inflight_cnt - CNT_W'(1);
        default: inflight_cnt <= inflight_cnt;
      endcase
    end
  end

endmodule

// ==== tcp_rx_sync.sv ====
`timescale 1ns/10ps

module tcp_rx_sync
  import tcp_rx_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,

  input  logic      pd_nempty,
  output logic      pd_ren,
  input  pkt_desc_t pd_rdata,

  input  logic      rslt_nempty,
  output logic      rslt_ren,
  input  seq_num_t  rslt_rdata,

  output logic      pair_vld,
  input  logic      pair_rdy,
  output pkt_desc_t pair_desc,
  output seq_num_t  pair_entry
);

  logic pop;

  // both heads leave together, so order is kept
  assign pop      = pd_nempty && rslt_nempty && (!pair_vld || pair_rdy);
  assign pd_ren   = pop;
  assign rslt_ren = pop;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pair_vld <= 1'b0;
    end else if (pop) begin
      pair_vld <= 1'b1;
    end else if (pair_rdy) begin
      pair_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      pair_desc  <= pd_rdata;
      pair_entry <= rslt_rdata;
    end
  end

endmodule

// ==== tcp_rx_tab_act.sv ====
`timescale 1ns/10ps
`include "tcp_rx_defs.svh"

module tcp_rx_tab_act
  import tcp_rx_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,

  input  logic      pair_vld,
  output logic      pair_rdy,
  input  pkt_desc_t pair_desc,
  input  seq_num_t  pair_entry,

  output logic      out_pd_vld,
  input  logic      out_pd_rdy,
  output out_desc_t out_pd_dat,

  output logic      tab_wr_wen,
  output flow_idx_t tab_wr_addr,
  output seq_num_t  tab_wr_data,
  input  logic      tab_wr_nafull,

  output logic      retire
);

  localparam int HIST_DEPTH = `TCP_RX_HIST_DEPTH;

  logic [HIST_DEPTH-1:0] hist_vld;
  flow_idx_t             hist_flow [HIST_DEPTH];
  seq_num_t              hist_seq [HIST_DEPTH];

  flow_idx_t   cur_flow;
  seq_num_t    cur_seq;
  pay_len_t    cur_len;
  tcp_flags_t  cur_flags;
  logic        hist_hit;
  seq_num_t    hist_val;
  seq_num_t    exp_seq;
  rx_verdict_e verdict;
  seq_num_t    new_seq;
  logic        complete;
  logic        do_wr;

  assign cur_flow  = desc_flow(pair_desc);
  assign cur_seq   = desc_seq(pair_desc);
  assign cur_len   = desc_len(pair_desc);
  assign cur_flags = desc_flags(pair_desc);

  // newest matching update wins, index 0 is newest
  always_comb begin
    hist_hit = 1'b0;
    hist_val = '0;
    for (int i = HIST_DEPTH - 1; i >= 0; i--) begin
      if (hist_vld[i] && (hist_flow[i] == cur_flow)) begin
        hist_hit = 1'b1;
        hist_val = hist_seq[i];
      end
    end
  end

  // table entry may predate writes still in the history
  assign exp_seq = hist_hit ? hist_val : pair_entry;

  always_comb begin
    if (cur_flags[SYN_BIT]) begin
      verdict = RX_SYN_INIT;
      new_seq = cur_seq + seq_num_t'(1);
    end else if (cur_seq == exp_seq) begin
      verdict = RX_ACCEPT;
      new_seq = cur_seq + seq_num_t'(cur_len);
    end else begin
      verdict = RX_DROP_OOO;
      new_seq = exp_seq;
    end
  end

  // output held back while the table write path is full
  assign out_pd_vld = pair_vld && tab_wr_nafull;
  assign out_pd_dat = {verdict, pair_desc};

  assign complete = pair_vld && out_pd_rdy && tab_wr_nafull;
  assign pair_rdy = complete;
  assign retire   = complete;

  // drops leave the table alone
  assign do_wr       = complete && (verdict != RX_DROP_OOO);
  assign tab_wr_wen  = do_wr;
  assign tab_wr_addr = cur_flow;
  assign tab_wr_data = new_seq;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hist_vld <= '0;
    end else if (do_wr) begin
      hist_vld <= {hist_vld[HIST_DEPTH-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      for (int i = HIST_DEPTH - 1; i > 0; i--) begin
        hist_flow[i] <= hist_flow[i-1];
        hist_seq[i]  <= hist_seq[i-1];
      end
      hist_flow[0] <= cur_flow;
      hist_seq[0]  <= new_seq;
    end
  end

endmodule

// ==== tcp_rx_top.sv ====
`timescale 1ns/10ps
`include "tcp_rx_defs.svh"

module tcp_rx_top
  import tcp_rx_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,

  input  logic      in_pd_vld,
  output logic      in_pd_rdy,
  input  pkt_desc_t in_pd_dat,

  output logic      tab_rreq_wen,
  output flow_idx_t tab_rreq_addr,
  input  logic      tab_rreq_nafull,

  input  logic      tab_rdat_wen,
  input  seq_num_t  tab_rdat_data,
  output logic      tab_rdat_nafull,

  output logic      tab_wr_wen,
  output flow_idx_t tab_wr_addr,
  output seq_num_t  tab_wr_data,
  input  logic      tab_wr_nafull,

  output logic      out_pd_vld,
  input  logic      out_pd_rdy,
  output out_desc_t out_pd_dat
);

  logic      pd_fifo_wen;
  pkt_desc_t pd_fifo_wdata;
  logic      pd_fifo_nafull;
  logic      pd_fifo_ren;
  pkt_desc_t pd_fifo_rdata;
  logic      pd_fifo_nempty;

  logic      rslt_fifo_ren;
  seq_num_t  rslt_fifo_rdata;
  logic      rslt_fifo_nempty;

  logic      pair_vld;
  logic      pair_rdy;
  pkt_desc_t pair_desc;
  seq_num_t  pair_entry;
  logic      retire;

  tcp_rx_tab_req u_tcp_rx_tab_req (
    .clk             (clk),
    .arst_n          (arst_n),
    .in_pd_vld       (in_pd_vld),
    .in_pd_rdy       (in_pd_rdy),
    .in_pd_dat       (in_pd_dat),
    .tab_rreq_wen    (tab_rreq_wen),
    .tab_rreq_addr   (tab_rreq_addr),
    .tab_rreq_nafull (tab_rreq_nafull),
    .pd_fifo_wen     (pd_fifo_wen),
    .pd_fifo_wdata   (pd_fifo_wdata),
    .pd_fifo_nafull  (pd_fifo_nafull),
    .retire          (retire)
  );

  sync_fifo #(
    .DWID ($bits(pkt_desc_t)),
    .AWID (`TCP_RX_PD_FIFO_AW)
  ) u_pd_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .wen    (pd_fifo_wen),
    .wdata  (pd_fifo_wdata),
    .nafull (pd_fifo_nafull),
    .ren    (pd_fifo_ren),
    .rdata  (pd_fifo_rdata),
    .nempty (pd_fifo_nempty)
  );

  // table results arrive in request order
  sync_fifo #(
    .DWID ($bits(seq_num_t)),
    .AWID (`TCP_RX_RSLT_FIFO_AW)
  ) u_rslt_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .wen    (tab_rdat_wen),
    .wdata  (tab_rdat_data),
    .nafull (tab_rdat_nafull),
    .ren    (rslt_fifo_ren),
    .rdata  (rslt_fifo_rdata),
    .nempty (rslt_fifo_nempty)
  );

  tcp_rx_sync u_tcp_rx_sync (
    .clk         (clk),
    .arst_n      (arst_n),
    .pd_nempty   (pd_fifo_nempty),
    .pd_ren      (pd_fifo_ren),
    .pd_rdata    (pd_fifo_rdata),
    .rslt_nempty (rslt_fifo_nempty),
    .rslt_ren    (rslt_fifo_ren),
    .rslt_rdata  (rslt_fifo_rdata),
    .pair_vld    (pair_vld),
    .pair_rdy    (pair_rdy),
    .pair_desc   (pair_desc),
    .pair_entry  (pair_entry)
  );

  tcp_rx_tab_act u_tcp_rx_tab_act (
    .clk           (clk),
    .arst_n        (arst_n),
    .pair_vld      (pair_vld),
    .pair_rdy      (pair_rdy),
    .pair_desc     (pair_desc),
    .pair_entry    (pair_entry),
    .out_pd_vld    (out_pd_vld),
    .out_pd_rdy    (out_pd_rdy),
    .out_pd_dat    (out_pd_dat),
    .tab_wr_wen    (tab_wr_wen),
    .tab_wr_addr   (tab_wr_addr),
    .tab_wr_data   (tab_wr_data),
    .tab_wr_nafull (tab_wr_nafull),
    .retire        (retire)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter real PERIOD_NS  = 4.0,
  parameter int  RST_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

  // release on a falling edge
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// ==== tb_table_model.sv ====
`timescale 1ns/10ps

module tb_table_model
  import tcp_rx_pkg::*;
#(
  parameter int unsigned SEED = 32'h1
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      bp_en,
  input  logic      tab_rreq_wen,
  input  flow_idx_t tab_rreq_addr,
  output logic      tab_rreq_nafull,
  output logic      tab_rdat_wen,
  output seq_num_t  tab_rdat_data,
  input  logic      tab_rdat_nafull,
  input  logic      tab_wr_wen,
  input  flow_idx_t tab_wr_addr,
  input  seq_num_t  tab_wr_data,
  output logic      tab_wr_nafull
);

  seq_num_t mem [256];
  seq_num_t rd_q [$];
  int       due_q [$];
  int       cyc;
  int       seed;
  logic     stall;

  initial begin
    seed            = SEED;
    cyc             = 0;
    tab_rreq_nafull = 1'b1;
    tab_rdat_wen    = 1'b0;
    tab_rdat_data   = '0;
    tab_wr_nafull   = 1'b1;
    for (int i = 0; i < 256; i++) begin
      mem[i] = seq_num_t'(32'h9e37_79b9 * i);
    end
  end

  // read sees the entry as it stood before a write in the same cycle
  always @(posedge clk) begin
    if (tab_rreq_wen) begin
      rd_q.push_back(mem[tab_rreq_addr]);
      due_q.push_back(cyc + int'($unsigned($random(seed)) % 6));
    end
    if (tab_wr_wen) begin
      mem[tab_wr_addr] = tab_wr_data;
    end
    cyc = cyc + 1;
  end

  // results in request order, paced by random stalls
  always @(negedge clk) begin
    stall = bp_en && (($random(seed) & 3) == 0);
    if (arst_n && !stall && tab_rdat_nafull && (rd_q.size() > 0) && (due_q[0] < cyc)) begin
      tab_rdat_wen  = 1'b1;
      tab_rdat_data = rd_q.pop_front();
      void'(due_q.pop_front());
    end else begin
      tab_rdat_wen = 1'b0;
    end
    tab_rreq_nafull = !(bp_en && (($random(seed) & 7) == 0));
    tab_wr_nafull   = !(bp_en && (($random(seed) & 3) == 0));
  end

endmodule

// ==== tb_tcp_rx.sv ====
`timescale 1ns/10ps

module tb_tcp_rx
  import tcp_rx_pkg::*;
();

  logic      clk;
  logic      arst_n;
  logic      in_pd_vld;
  logic      in_pd_rdy;
  pkt_desc_t in_pd_dat;
  logic      tab_rreq_wen;
  flow_idx_t tab_rreq_addr;
  logic      tab_rreq_nafull;
  logic      tab_rdat_wen;
  seq_num_t  tab_rdat_data;
  logic      tab_rdat_nafull;
  logic      tab_wr_wen;
  flow_idx_t tab_wr_addr;
  seq_num_t  tab_wr_data;
  logic      tab_wr_nafull;
  logic      out_pd_vld;
  logic      out_pd_rdy;
  out_desc_t out_pd_dat;
  logic      bp_en;

  int        seed = 32'he009_db89;
  int        mismatches = 0;
  int        failures = 0;
  int        timeouts = 0;
  string     test_name = "none";
  seq_num_t  ref_tab [256];
  out_desc_t exp_q [$];

  tb_clk_gen u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  tcp_rx_top i_dut (.*);

  tb_table_model #(
    .SEED (32'he009_db89)
  ) u_table (.*);

  // flow 63:56, seq 55:24, len 23:8, flags 7:0 with SYN at bit 1
  function automatic out_desc_t predict(pkt_desc_t d);
    flow_idx_t   flow;
    seq_num_t    seq;
    rx_verdict_e v;
    flow = d[63:56];
    seq  = d[55:24];
    if (d[1]) begin
      v = RX_SYN_INIT;
      ref_tab[flow] = seq + 32'd1;
    end else if (seq == ref_tab[flow]) begin
      v = RX_ACCEPT;
      ref_tab[flow] = seq + 32'(d[23:8]);
    end else begin
      v = RX_DROP_OOO;
    end
    return {v, d};
  endfunction

  task automatic compare(string what, logic [65:0] exp_v, logic [65:0] act_v);
    assert (act_v === exp_v) else begin
      mismatches++;
      $display("Mismatch %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic end_run();
    $display("errors: %0d mismatch, %0d check, %0d timeout", mismatches, failures, timeouts);
    if ((mismatches == 0) && (failures == 0) && (timeouts == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic give_up(string what);
    timeouts++;
    $display("timeout in %s while %s", test_name, what);
    end_run();
  endtask

  // called at a falling edge, returns at the accepting rising edge
  task automatic send(flow_idx_t flow, seq_num_t seq, pay_len_t len, tcp_flags_t flags);
    int n;
    n = 0;
    in_pd_vld = 1'b1;
    in_pd_dat = {flow, seq, len, flags};
    @(posedge clk);
    while (!in_pd_rdy) begin
      n++;
      if (n == 200) begin
        give_up("waiting for the DUT to take a descriptor");
      end
      @(posedge clk);
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(negedge clk);
    in_pd_vld = 1'b0;
    while (exp_q.size() > 0) begin
      n++;
      if (n == 2000) begin
        give_up("waiting for outstanding descriptors to come out");
      end
      @(negedge clk);
    end
  endtask

  // reference model runs in send order
  always @(posedge clk) begin
    out_desc_t exp_out;
    if (in_pd_vld && in_pd_rdy) begin
      exp_q.push_back(predict(in_pd_dat));
    end
    if (out_pd_vld && out_pd_rdy) begin
      assert (exp_q.size() > 0) else begin
        failures++;
        $display("output descriptor in %s with nothing outstanding", test_name);
      end
      if (exp_q.size() > 0) begin
        exp_out = exp_q.pop_front();
        compare("output", exp_out, out_pd_dat);
      end
    end
  end

  always @(negedge clk) begin
    if (bp_en) begin
      out_pd_rdy = (($random(seed) & 3) != 0);
    end else begin
      out_pd_rdy = 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) tab_rreq_wen |-> tab_rreq_nafull)
    else begin
      failures++;
      $display("table read request while tab_rreq_nafull was low");
    end

  assert property (@(posedge clk) disable iff (!arst_n) tab_wr_wen |-> tab_wr_nafull)
    else begin
      failures++;
      $display("table write while tab_wr_nafull was low");
    end

  initial begin
    int          n;
    seq_num_t    s;
    logic [31:0] r;
    flow_idx_t   f;
    tcp_flags_t  fl;
    in_pd_vld  = 1'b0;
    in_pd_dat  = '0;
    out_pd_rdy = 1'b1;
    bp_en      = 1'b0;

    test_name = "reset";
    n = 0;
    while (arst_n !== 1'b1) begin
      n++;
      if (n == 20) begin
        give_up("waiting for reset release");
      end
      @(negedge clk);
    end
    for (int i = 0; i < 256; i++) begin
      ref_tab[i] = u_table.mem[i];
    end
    repeat (3) begin
      @(posedge clk);
      assert (!in_pd_rdy && !tab_rreq_wen && !tab_wr_wen && !out_pd_vld) else begin
        failures++;
        $display("handshake output high after reset with no stimulus");
      end
    end

    test_name = "syn";
    @(negedge clk);
    send(8'd10, 32'd1000, 16'd0, 8'h02);
    drain();
    compare("table entry", 32'd1001, u_table.mem[10]);

    // back to back, so lookups run ahead of write-backs
    test_name = "in_order";
    s = 32'd1001;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      send(8'd10, s, pay_len_t'(40 + 8 * i), 8'h10);
      s = s + 32'(40 + 8 * i);
    end
    drain();
    compare("table entry", s, u_table.mem[10]);

    test_name = "out_of_order";
    @(negedge clk);
    send(8'd10, s + 32'd7, 16'd20, 8'h10);
    drain();
    compare("table entry", s, u_table.mem[10]);

    test_name = "random";
    bp_en = 1'b1;
    for (int i = 0; i < 300; i++) begin
      @(negedge clk);
      r = $random(seed);
      if (r[31:30] == 2'b00) begin
        in_pd_vld = 1'b0;
        @(negedge clk);
      end
      f  = flow_idx_t'(8'd20 + r[29:28]);
      fl = {r[27:22], (r[21:19] == 3'd0), r[18]};
      s  = (r[17:16] == 2'd0) ? ref_tab[f] + r[15:8] + 32'd1 : ref_tab[f];
      send(f, s, pay_len_t'(r[7:0]), fl);
    end
    drain();
    bp_en = 1'b0;
    end_run();
  end

endmodule

// ==== sim.f ====
+incdir+.
tcp_rx_pkg.sv
sync_fifo.sv
tcp_rx_tab_req.sv
tcp_rx_sync.sv
tcp_rx_tab_act.sv
tcp_rx_top.sv
tb_clk_gen.sv
tb_table_model.sv
tb_tcp_rx.sv
